/* Makefile */
TOP = cpu_ctl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f cpu_ctl.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f cpu_ctl.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log || ! grep -q '\*\* PASS \*\*' sim.log; then \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* cpu_ctl.f */
verilog/cpu_pkg.sv
verilog/ctl_pkg.sv
verilog/opcode_decoder.sv
verilog/sequencer.sv
verilog/addr_op_encoder.sv
verilog/micro_op_encoder.sv
verilog/cpu_ctl.sv
test/cpu_ctl_assert.sv
test/cpu_ctl_tb.sv

/* test/cpu_ctl_assert.sv */
`timescale 1ns/1ps

module cpu_ctl_assert
    import cpu_pkg::*;
(
    input logic  clk,
    input logic  arst_n,
    input logic  sync,
    input logic  we,
    input byte_t db
);

    logic known_op;                         // Byte starts a real sequence

    assign known_op = db inside {OP_BRK, OP_ASL_ZP, OP_ASL_ZPX, OP_JSR, OP_RTI, OP_PHA,
        OP_JMP_ABS, OP_RTS, OP_PLA, OP_ADC_IMM, OP_JMP_IND, OP_JMP_INDX, OP_BRA,
        OP_LDY_IMM, OP_LDA_INDX, OP_LDX_IMM, OP_LDA_ZP, OP_LDA_IMM, OP_LDA_ABS,
        OP_LDA_INDY, OP_LDA_IND, OP_LDA_ZPX, OP_LDX_ZPY, OP_LDA_ABSY, OP_LDA_ABSX,
        OP_INC_ZP, OP_INC_ABS};

    a_we_init: assert property (@(posedge clk) $rose(arst_n) |=> !we)
        else $error("we high in the cycle after reset release");
    a_sync_single: assert property (@(posedge clk) disable iff (!arst_n)
        sync && known_op |=> !sync)
        else $error("sync high twice in a row for a supported opcode");
    a_we_sync: assert property (@(posedge clk) disable iff (!arst_n) sync |-> !we)
        else $error("we high during opcode fetch");

endmodule

bind cpu_ctl cpu_ctl_assert u_assert (
    .clk(clk), .arst_n(arst_n), .sync(sync), .we(we), .db(db)
);

/* test/cpu_ctl_tb.sv */
`timescale 1ns/1ps

module cpu_ctl_tb
    import cpu_pkg::*, ctl_pkg::*;
;

    localparam int       NUM_INSTR = 3000;
    localparam int       MAX_LEN   = 12;    // Longest wait for the next sync
    localparam ab_mode_t COND_MODE = 4'd7;  // Branch offset mode

    logic    clk = 1'b0;
    logic    arst_n;
    byte_t   db;
    logic    cond;
    logic    sync;
    logic    we;
    ab_op_t  ab_op;
    reg_op_t reg_op;
    alu_op_t alu_op;
    do_sel_t do_op;

    integer  seed = 78058;
    reg_op_t exp_reg;                       // Selection latched from the last fetch
    alu_fn_t exp_alu;
    opcode_t supported [$] = '{OP_BRK, OP_ASL_ZP, OP_ASL_ZPX, OP_JSR, OP_RTI, OP_PHA,
        OP_JMP_ABS, OP_RTS, OP_PLA, OP_ADC_IMM, OP_JMP_IND, OP_JMP_INDX, OP_BRA,
        OP_LDY_IMM, OP_LDA_INDX, OP_LDX_IMM, OP_LDA_ZP, OP_LDA_IMM, OP_LDA_ABS,
        OP_LDA_INDY, OP_LDA_IND, OP_LDA_ZPX, OP_LDX_ZPY, OP_LDA_ABSY, OP_LDA_ABSX,
        OP_INC_ZP, OP_INC_ABS};

    cpu_ctl DUT (
        .clk(clk), .arst_n(arst_n), .db(db), .cond(cond), .sync(sync), .we(we),
        .ab_op(ab_op), .reg_op(reg_op), .alu_op(alu_op), .do_op(do_op)
    );

    always #5 clk = ~clk;                   // 100 MHz

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_sync(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_run($sformatf("FAILED at %0t: sync %b, expected %b (%s)", $time, got, exp, what));
    endtask

    task automatic check_we(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_run($sformatf("FAILED at %0t: we %b, expected %b (%s)", $time, got, exp, what));
    endtask

    task automatic check_ab_op(input ab_op_t got, input ab_op_t exp);
        if (got !== exp)
            stop_run($sformatf("FAILED at %0t: ab_op %h, expected %h", $time, got, exp));
    endtask

    task automatic check_reg_op(input reg_op_t got, input reg_op_t exp);
        if (got !== exp)
            stop_run($sformatf("FAILED at %0t: reg_op %h, expected %h", $time, got, exp));
    endtask

    task automatic check_alu_op(input alu_op_t got, input alu_op_t exp);
        if (got !== exp)
            stop_run($sformatf("FAILED at %0t: alu_op %h, expected %h", $time, got, exp));
    endtask

    task automatic check_do_op(input do_sel_t got, input do_sel_t exp, input string what);
        if (got !== exp)
            stop_run($sformatf("FAILED at %0t: do_op %0d, expected %0d (%s)",
                               $time, got, exp, what));
    endtask

    task automatic check_len(input int got, input int exp, input string what);
        if (got != exp)
            stop_run($sformatf("FAILED at %0t: %0d cycles, expected %0d (%s)",
                               $time, got, exp, what));
    endtask

    // Cycles from one sync to the next
    function automatic int instr_len(input opcode_t op);
        case (op)
            OP_BRA, OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_ADC_IMM: return 2;
            OP_JMP_ABS, OP_LDA_ZP, OP_LDA_ZPX, OP_LDX_ZPY, OP_ASL_ZPX,
            OP_PHA, OP_PLA: return 3;
            OP_ASL_ZP, OP_INC_ZP, OP_LDA_ABS, OP_LDA_ABSX, OP_LDA_ABSY, OP_RTS: return 4;
            OP_JMP_IND, OP_JMP_INDX, OP_LDA_IND, OP_LDA_INDX, OP_LDA_INDY,
            OP_INC_ABS, OP_JSR, OP_RTI: return 5;
            OP_BRK: return 7;
            default: return 1;              // Unknown byte, fetch again
        endcase
    endfunction

    // Bit n set when we is high n cycles after the sync cycle
    function automatic logic [15:0] we_cycles(input opcode_t op);
        case (op)
            OP_BRK:               return 16'h001C;  // PCH, PCL, P
            OP_JSR:               return 16'h000C;  // PCH, PCL
            OP_PHA:               return 16'h0004;
            OP_ASL_ZP, OP_INC_ZP: return 16'h0008;  // RMW write back
            OP_INC_ABS:           return 16'h0010;
            default:              return 16'h0000;
        endcase
    endfunction

    // Data-out source n cycles after the sync cycle
    function automatic do_sel_t push_data(input opcode_t op, input int n);
        do_sel_t d;
        d = DO_ALU;
        if (op == OP_BRK || op == OP_JSR) begin
            if (n == 2)
                d = DO_PCH;                 // Return address high first
            else if (n == 3)
                d = DO_PCL;
            else if (n == 4 && op == OP_BRK)
                d = DO_P;                   // Status last
        end
        return d;
    endfunction

    function automatic ab_op_t cond_word(input logic back);
        ab_ent_t e;
        e = back ? AB_OP_BACK : AB_OP_FWD;
        return {e.hi, COND_MODE[1:0], e.abl, COND_MODE[2]};
    endfunction

    // Register and ALU selection that the next sync cycle shows
    task automatic latch_decode(input opcode_t op);
        exp_alu = ALU_FN_NONE;
        case (op)
            OP_LDA_IND, OP_LDA_INDX, OP_LDA_INDY, OP_LDA_ZP, OP_LDA_ZPX,
            OP_LDA_IMM, OP_LDA_ABS, OP_LDA_ABSX, OP_LDA_ABSY, OP_PLA: begin
                exp_reg = '{1'b1, DST_A, REG_Z};    // A gets 0 + M
                exp_alu = ALU_FN_LOAD;
            end
            OP_LDX_IMM, OP_LDX_ZPY: begin
                exp_reg = '{1'b1, DST_X, REG_Z};
                exp_alu = ALU_FN_LOAD;
            end
            OP_LDY_IMM: begin
                exp_reg = '{1'b1, DST_Y, REG_Z};
                exp_alu = ALU_FN_LOAD;
            end
            OP_DEX, OP_INX: begin
                exp_reg = '{1'b1, DST_X, REG_X};
                exp_alu = (op == OP_DEX) ? ALU_FN_DEC : ALU_FN_INC;
            end
            OP_ADC_IMM: begin
                exp_reg = '{1'b1, DST_A, REG_A};
                exp_alu = ALU_FN_ADC;
            end
            OP_PHA: begin
                exp_reg.src = REG_A;        // ld and dst keep old value
                exp_alu     = ALU_FN_LOAD;
            end
            OP_INC_ZP, OP_INC_ABS: begin
                exp_reg.src = REG_M;
                exp_alu     = ALU_FN_LOAD;
            end
            default: ;
        endcase
    endtask

    task automatic pick_opcode(output opcode_t op);
        logic [31:0] rnd;
        int          idx;
        rnd = $random(seed);
        idx = int'(rnd[23:16]) % supported.size();
        if (rnd[3:0] == 4'd0)
            op = rnd[15:8];                 // Any byte, mostly unsupported
        else
            op = supported[idx];
    endtask

    // Called at the falling edge of a sync cycle
    task automatic run_instr(input opcode_t op);
        logic [15:0] we_mask;
        logic [31:0] rnd;
        int          n;
        we_mask = we_cycles(op);
        rnd     = $random(seed);
        db      = op;
        cond    = rnd[0];
        for (n = 1; n <= MAX_LEN; n++) begin
            @(negedge clk);
            if (sync)
                break;
            check_we(we, we_mask[n], $sformatf("opcode %h cycle %0d", op, n));
            check_do_op(do_op, push_data(op, n), $sformatf("opcode %h cycle %0d", op, n));
            rnd  = $random(seed);
            db   = rnd[7:0];                // Operand byte
            cond = rnd[8];
            if (op == OP_BRA && n == 1) begin
                #2;                         // Let ab_op settle on new db and cond
                check_ab_op(ab_op, cond_word(cond & db[7]));
            end
        end
        if (n > MAX_LEN)
            stop_run($sformatf("Timeout: sync did not return within %0d cycles after opcode %h",
                               MAX_LEN, op));
        check_len(n, instr_len(op), $sformatf("opcode %h", op));
    endtask

    initial begin
        int      i;
        int      n;
        opcode_t op;
        arst_n  = 1'b0;
        db      = '0;
        cond    = 1'b0;
        exp_reg = '0;                       // Decode cleared by reset
        exp_alu = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_sync(sync, 1'b0, "during reset");
        arst_n = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            check_we(we, 1'b0, "after reset");
        end while (!sync && n < MAX_LEN);
        if (!sync)
            stop_run("Timeout: sync never went high after reset release");
        check_len(n, 1, "INIT after reset");
        for (i = 0; i < NUM_INSTR; i++) begin
            check_we(we, 1'b0, "opcode fetch");
            check_do_op(do_op, DO_ALU, "opcode fetch");
            check_reg_op(reg_op, exp_reg);
            check_alu_op(alu_op, {2'b00, exp_alu});  // ldm and bcd clear
            pick_opcode(op);
            latch_decode(op);
            run_instr(op);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

/* verilog/addr_op_encoder.sv */
`timescale 1ns/1ps

module addr_op_encoder
    import cpu_pkg::*, ctl_pkg::*;
(
    input  ctl_state_e state,
    input  byte_t      db,
    input  logic       cond,
    output ab_op_t     ab_op
);

    ab_mode_t mode;
    ab_ent_t  ent;
    logic     back;                         // Taken backward branch

    assign back = cond & db[7];             // Sign of branch offset

    always_comb begin
        case (state)
            INIT:             mode = 4'd0;
            RDWR:             mode = 4'd0;  // Hold address for write back
            DATA, JSR2:       mode = 4'd1;
            ABS1, RTI3:       mode = 4'd2;
            IND0, ZERO:       mode = 4'd3;
            SYNC, ABS0, IMM0: mode = 4'd4;
            PULL:             mode = 4'd5;
            RTS0, RTS1:       mode = 4'd5;
            RTI0, RTI1, RTI2: mode = 4'd5;
            COND:             mode = 4'd7;
            JSR1, BRK1, BRK2: mode = 4'd8;
            JSR0, BRK0:       mode = 4'd9;
            IND2:             mode = 4'd10;
            PUSH:             mode = 4'd11;
            IND1:             mode = 4'd12;
            RTS2:             mode = 4'd14; // Return address + 1
            BRK3:             mode = 4'd15;
            default:          mode = 4'd0;
        endcase
    end

    always_comb begin
        case (mode)
            4'd0:    ent = AB_OP_HOLD;
            4'd1:    ent = AB_OP_PC;
            4'd2:    ent = AB_OP_ABS_ST;
            4'd3:    ent = AB_OP_ZP;
            4'd4:    ent = AB_OP_NEXT_ST;
            4'd5:    ent = AB_OP_POP;
            4'd7:    ent = back ? AB_OP_BACK : AB_OP_FWD;  // ABH gets FF or 00
            4'd8:    ent = AB_OP_SP;
            4'd9:    ent = AB_OP_SP_ST;
            4'd10:   ent = AB_OP_ABS;
            4'd11:   ent = AB_OP_PUSH;
            4'd12:   ent = AB_OP_NEXT;
            4'd14:   ent = AB_OP_ABS_INC;
            4'd15:   ent = AB_OP_VEC;
            default: ent = '0;              // Modes 6 and 13 unused
        endcase
    end

    // Mode bits 1:0 select the ABL mux, bit 2 is the ABL carry in
    assign ab_op = {ent.hi, mode[1:0], ent.abl, mode[2]};

endmodule

/* verilog/cpu_ctl.sv */
`timescale 1ns/1ps

module cpu_ctl
    import cpu_pkg::*, ctl_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  byte_t   db,
    input  logic    cond,
    output logic    sync,
    output logic    we,
    output ab_op_t  ab_op,
    output reg_op_t reg_op,
    output alu_op_t alu_op,
    output do_sel_t do_op
);

    decode_t    dec;                        // Latched instruction flags
    ctl_state_e state;

    opcode_decoder u_decoder (
        .clk(clk), .arst_n(arst_n), .sync(sync), .state(state), .db(db), .dec(dec)
    );

    sequencer u_sequencer (
        .clk(clk), .arst_n(arst_n), .db(db), .dec(dec), .state(state), .sync(sync)
    );

    addr_op_encoder u_addr_op (
        .state(state), .db(db), .cond(cond), .ab_op(ab_op)
    );

    micro_op_encoder u_micro_op (
        .clk(clk),
        .arst_n(arst_n),
        .state(state),
        .dec(dec),
        .reg_op(reg_op),
        .alu_op(alu_op),
        .do_op(do_op),
        .we(we)
    );

endmodule

/* verilog/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [7:0] byte_t;             // Data bus value
    typedef logic [7:0] opcode_t;           // Instruction byte
    typedef logic [3:0] reg_sel_t;          // Register file source select
    typedef logic [1:0] dst_sel_t;          // Register file destination select

    // Supported opcodes
    localparam opcode_t OP_BRK      = 8'h00;
    localparam opcode_t OP_ASL_ZP   = 8'h06;
    localparam opcode_t OP_ASL_ZPX  = 8'h16;
    localparam opcode_t OP_JSR      = 8'h20;
    localparam opcode_t OP_RTI      = 8'h40;
    localparam opcode_t OP_PHA      = 8'h48;
    localparam opcode_t OP_JMP_ABS  = 8'h4C;
    localparam opcode_t OP_RTS      = 8'h60;
    localparam opcode_t OP_PLA      = 8'h68;
    localparam opcode_t OP_ADC_IMM  = 8'h69;
    localparam opcode_t OP_JMP_IND  = 8'h6C;
    localparam opcode_t OP_JMP_INDX = 8'h7C;
    localparam opcode_t OP_BRA      = 8'h80;
    localparam opcode_t OP_LDY_IMM  = 8'hA0;
    localparam opcode_t OP_LDA_INDX = 8'hA1;    // (ZP,X)
    localparam opcode_t OP_LDX_IMM  = 8'hA2;
    localparam opcode_t OP_LDA_ZP   = 8'hA5;
    localparam opcode_t OP_LDA_IMM  = 8'hA9;
    localparam opcode_t OP_LDA_ABS  = 8'hAD;
    localparam opcode_t OP_LDA_INDY = 8'hB1;    // (ZP),Y
    localparam opcode_t OP_LDA_IND  = 8'hB2;    // (ZP)
    localparam opcode_t OP_LDA_ZPX  = 8'hB5;
    localparam opcode_t OP_LDX_ZPY  = 8'hB6;
    localparam opcode_t OP_LDA_ABSY = 8'hB9;
    localparam opcode_t OP_LDA_ABSX = 8'hBD;
    localparam opcode_t OP_DEX      = 8'hCA;    // Decoded only, no sequence
    localparam opcode_t OP_INC_ZP   = 8'hE6;
    localparam opcode_t OP_INX      = 8'hE8;    // Decoded only, no sequence
    localparam opcode_t OP_INC_ABS  = 8'hEE;

    localparam reg_sel_t REG_X   = 4'd0;
    localparam reg_sel_t REG_Y   = 4'd1;
    localparam reg_sel_t REG_A   = 4'd2;
    localparam reg_sel_t REG_S   = 4'd3;
    localparam reg_sel_t REG_M   = 4'd5;        // Memory operand
    localparam reg_sel_t REG_Z   = 4'd7;        // Constant zero
    localparam reg_sel_t REG_VEC = 4'd10;       // BRK vector

    localparam dst_sel_t DST_X = 2'd0;
    localparam dst_sel_t DST_Y = 2'd1;
    localparam dst_sel_t DST_A = 2'd2;
    localparam dst_sel_t DST_S = 2'd3;

endpackage

/* verilog/ctl_pkg.sv */
package ctl_pkg;
    import cpu_pkg::*;

    typedef enum logic [5:0] {
        INIT, SYNC, IMM0, IND0, IND1, IND2, DATA, ABS0, ABS1, ZERO,
        PULL, RDWR, RTS0, RTS1, RTS2, PUSH, JSR0, JSR1, JSR2,
        BRK0, BRK1, BRK2, BRK3, RTI0, RTI1, RTI2, RTI3, COND
    } ctl_state_e;

    typedef logic [3:0]  ab_mode_t;         // Compressed AB datapath mode
    typedef logic [11:0] ab_op_t;           // {upper, abl_sel, abl_op, abl_ci}
    typedef logic [6:0]  alu_fn_t;          // {shift, add, carry}
    typedef logic [1:0]  do_sel_t;

    typedef struct packed {
        logic     wr;                       // Write back to dst
        dst_sel_t dst;
        reg_sel_t src;
    } reg_op_t;

    typedef struct packed {
        logic       ldm;                    // Load M into ALU
        logic       bcd;
        logic [1:0] shift;                  // 10 left, 11 right
        logic [2:0] add;                    // OR AND XOR ADD INC DEC SUB TRB
        logic [1:0] carry;                  // 01 one, 10 rotate, 11 ADC
    } alu_op_t;

    typedef struct packed {
        logic rmw, jmp, ind, add_x, add_y, ld, st;
        dst_sel_t dst;
        reg_sel_t src;
        alu_fn_t  alu;
    } decode_t;

    typedef struct packed {
        logic [6:0] hi;                     // PC, AHL and ABH controls
        logic [1:0] abl;                    // ABL operation
    } ab_ent_t;

    // One entry per AB mode
    localparam ab_ent_t AB_OP_HOLD    = '{7'b001_0110, 2'b11};  // AB + 0
    localparam ab_ent_t AB_OP_PC      = '{7'b000_1010, 2'b10};  // PC
    localparam ab_ent_t AB_OP_ABS_ST  = '{7'b111_1110, 2'b01};  // {DB, AHL+REG}, store PC
    localparam ab_ent_t AB_OP_ZP      = '{7'b111_0000, 2'b01};  // {00, DB+REG}
    localparam ab_ent_t AB_OP_NEXT_ST = '{7'b011_0110, 2'b11};  // AB + 1, store PC
    localparam ab_ent_t AB_OP_POP     = '{7'b011_0001, 2'b00};  // {01, SP+1}
    localparam ab_ent_t AB_OP_BACK    = '{7'b011_0111, 2'b11};  // Backward branch
    localparam ab_ent_t AB_OP_FWD     = '{7'b011_0110, 2'b11};  // Forward or not taken
    localparam ab_ent_t AB_OP_SP      = '{7'b000_0001, 2'b00};  // {01, SP}, keep PC
    localparam ab_ent_t AB_OP_SP_ST   = '{7'b111_0001, 2'b00};  // {01, SP}, store PC+1
    localparam ab_ent_t AB_OP_ABS     = '{7'b001_1110, 2'b01};  // {DB, AHL+REG}, keep PC
    localparam ab_ent_t AB_OP_PUSH    = '{7'b010_0001, 2'b00};  // {01, SP}
    localparam ab_ent_t AB_OP_NEXT    = '{7'b001_0110, 2'b11};  // AB + 1, keep PC
    localparam ab_ent_t AB_OP_ABS_INC = '{7'b001_1110, 2'b01};  // {DB, AHL+REG} + 1
    localparam ab_ent_t AB_OP_VEC     = '{7'b000_0011, 2'b00};  // {FF, REG} + 1

    localparam alu_fn_t ALU_FN_LOAD = 7'b00_011_00;
    localparam alu_fn_t ALU_FN_DEC  = 7'b00_101_00;
    localparam alu_fn_t ALU_FN_INC  = 7'b00_100_01;
    localparam alu_fn_t ALU_FN_ADC  = 7'b00_011_11;
    localparam alu_fn_t ALU_FN_NONE = 7'b11_111_11;

    localparam alu_op_t ALU_OP_DEC1 = 9'b00_00_101_00;     // Stack pointer - 1
    localparam alu_op_t ALU_OP_INC1 = 9'b00_00_100_01;     // Stack pointer + 1
    localparam alu_op_t ALU_OP_LDM  = 9'b10_00_000_00;
    localparam alu_op_t ALU_OP_STM  = 9'b00_00_100_00;

    localparam reg_op_t REG_OP_STACK = '{1'b1, DST_S, REG_S};
    localparam reg_op_t REG_OP_VEC   = '{1'b0, DST_X, REG_VEC};

    localparam do_sel_t DO_ALU = 2'd0;
    localparam do_sel_t DO_P   = 2'd1;
    localparam do_sel_t DO_PCL = 2'd2;
    localparam do_sel_t DO_PCH = 2'd3;

endpackage

/* verilog/micro_op_encoder.sv */
`timescale 1ns/1ps

module micro_op_encoder
    import cpu_pkg::*, ctl_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  ctl_state_e state,
    input  decode_t    dec,
    output reg_op_t    reg_op,
    output alu_op_t    alu_op,
    output do_sel_t    do_op,
    output logic       we
);

    reg_sel_t idx_x;                        // X or zero
    reg_sel_t idx_y;                        // Y or zero
    reg_sel_t idx_xy;                       // X, else Y, else zero

    assign idx_x  = dec.add_x ? REG_X : REG_Z;
    assign idx_y  = dec.add_y ? REG_Y : REG_Z;
    assign idx_xy = dec.add_x ? REG_X : idx_y;

    always_comb begin
        case (state)
            BRK0, BRK1, BRK2, JSR0, JSR1, PUSH: reg_op = REG_OP_STACK;
            RTS0, RTS1, RTI0, RTI1, RTI2, PULL: reg_op = REG_OP_STACK;
            BRK3:       reg_op = REG_OP_VEC;
            IND0:       reg_op = '{1'b0, DST_X, idx_x};    // Pre-index
            IND2:       reg_op = '{1'b0, DST_X, idx_y};    // Post-index
            ZERO, ABS1: reg_op = '{1'b0, DST_X, idx_xy};
            SYNC:       reg_op = '{dec.ld, dec.dst, dec.src};  // dst <= src op M
            DATA:       reg_op = '{1'b0, dec.dst, dec.src};    // Store source
            default:    reg_op = '{1'b0, DST_X, REG_Z};
        endcase
    end

    always_comb begin
        case (state)
            BRK0, BRK1, BRK2, JSR0, JSR1, PUSH: alu_op = ALU_OP_DEC1;
            RTS0, RTS1, RTI0, RTI1, RTI2, PULL: alu_op = ALU_OP_INC1;
            IMM0, RDWR: alu_op = ALU_OP_LDM;
            SYNC:       alu_op = {2'b00, dec.alu};   // Finish previous opcode
            DATA: begin
                if (dec.st)
                    alu_op = ALU_OP_STM;
                else
                    alu_op = {2'b10, dec.alu};       // Load or RMW
            end
            default:    alu_op = '0;
        endcase
    end

    always_comb begin
        case (state)
            BRK1, JSR1: do_op = DO_PCH;
            BRK2, JSR2: do_op = DO_PCL;
            BRK3:       do_op = DO_P;
            default:    do_op = DO_ALU;
        endcase
    end

    // Write strobe lands on the cycle after each write state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            we <= 1'b0;
        else
            we <= state inside {BRK0, BRK1, BRK2, JSR0, JSR1, PUSH, RDWR};
    end

endmodule

/* verilog/opcode_decoder.sv */
`timescale 1ns/1ps

module opcode_decoder
    import cpu_pkg::*, ctl_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       sync,
    input  ctl_state_e state,
    input  byte_t      db,
    output decode_t    dec
);

    decode_t nxt;                           // Decode of current opcode byte

    always_comb begin
        nxt       = dec;                    // ld, dst, src hold by default
        nxt.rmw   = 1'b0;
        nxt.jmp   = 1'b0;
        nxt.ind   = 1'b0;
        nxt.add_x = 1'b0;
        nxt.add_y = 1'b0;
        nxt.st    = 1'b0;
        nxt.alu   = ALU_FN_NONE;

        case (db)                           // Control flow and RMW flags
            OP_BRK, OP_JSR, OP_RTI, OP_RTS, OP_JMP_ABS: nxt.jmp = 1'b1;
            OP_JMP_IND, OP_JMP_INDX: begin
                nxt.jmp = 1'b1;
                nxt.ind = 1'b1;             // Extra ABS0/ABS1 pass
            end
            OP_ASL_ZP: nxt.rmw = 1'b1;
            OP_INC_ZP, OP_INC_ABS: begin
                nxt.rmw = 1'b1;
                nxt.src = REG_M;
                nxt.alu = ALU_FN_LOAD;
            end
            default: ;
        endcase

        case (db)                           // Index register selection
            OP_JMP_INDX, OP_LDA_INDX, OP_LDA_ZPX, OP_LDA_ABSX: nxt.add_x = 1'b1;
            OP_LDA_INDY, OP_LDX_ZPY, OP_LDA_ABSY:             nxt.add_y = 1'b1;
            default: ;
        endcase

        case (db)                           // Register loads and stores
            OP_LDA_IND, OP_LDA_INDX, OP_LDA_INDY, OP_LDA_ZP, OP_LDA_ZPX,
            OP_LDA_IMM, OP_LDA_ABS, OP_LDA_ABSX, OP_LDA_ABSY, OP_PLA: begin
                nxt.ld  = 1'b1;
                nxt.dst = DST_A;
                nxt.src = REG_Z;            // A <= 0 + M
                nxt.alu = ALU_FN_LOAD;
            end
            OP_LDX_IMM, OP_LDX_ZPY: begin
                nxt.ld  = 1'b1;
                nxt.dst = DST_X;
                nxt.src = REG_Z;
                nxt.alu = ALU_FN_LOAD;
            end
            OP_LDY_IMM: begin
                nxt.ld  = 1'b1;
                nxt.dst = DST_Y;
                nxt.src = REG_Z;
                nxt.alu = ALU_FN_LOAD;
            end
            OP_DEX, OP_INX: begin
                nxt.ld  = 1'b1;
                nxt.dst = DST_X;
                nxt.src = REG_X;
                nxt.alu = (db == OP_DEX) ? ALU_FN_DEC : ALU_FN_INC;
            end
            OP_PHA: begin
                nxt.st  = 1'b1;
                nxt.src = REG_A;
                nxt.alu = ALU_FN_LOAD;
            end
            OP_ADC_IMM: begin
                nxt.ld  = 1'b1;
                nxt.dst = DST_A;
                nxt.src = REG_A;
                nxt.alu = ALU_FN_ADC;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec <= '0;
        end else if (sync) begin
            dec <= nxt;                     // Latch at opcode fetch
        end else if (state == ABS1) begin
            dec.ind   <= 1'b0;              // Indirection resolves once
            dec.add_x <= 1'b0;              // JMP (IND,X) index used once
        end
    end

endmodule

/* verilog/sequencer.sv */
`timescale 1ns/1ps

module sequencer
    import cpu_pkg::*, ctl_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  byte_t      db,
    input  decode_t    dec,
    output ctl_state_e state,
    output logic       sync
);

    ctl_state_e state_d;

    always_comb begin
        state_d = state;                    // Unknown opcode stays in SYNC
        case (state)
            INIT: state_d = SYNC;
            SYNC: begin
                case (db)
                    OP_BRA:                                  state_d = COND;
                    OP_BRK:                                  state_d = BRK0;
                    OP_JSR:                                  state_d = JSR0;
                    OP_RTI:                                  state_d = RTI0;
                    OP_RTS:                                  state_d = RTS0;
                    OP_PHA:                                  state_d = PUSH;
                    OP_PLA:                                  state_d = PULL;
                    OP_JMP_ABS, OP_JMP_IND, OP_JMP_INDX:     state_d = ABS0;
                    OP_LDA_ABS, OP_LDA_ABSX, OP_LDA_ABSY:    state_d = ABS0;
                    OP_INC_ABS:                              state_d = ABS0;
                    OP_ASL_ZP, OP_ASL_ZPX, OP_INC_ZP:        state_d = ZERO;
                    OP_LDA_ZP, OP_LDA_ZPX, OP_LDX_ZPY:       state_d = ZERO;
                    OP_LDA_INDX, OP_LDA_IND, OP_LDA_INDY:    state_d = IND0;
                    OP_LDA_IMM, OP_LDY_IMM, OP_LDX_IMM:      state_d = IMM0;
                    OP_ADC_IMM:                              state_d = IMM0;
                    default: ;
                endcase
            end
            IND0: state_d = IND1;
            IND1: state_d = IND2;
            IND2: state_d = DATA;
            IMM0: state_d = SYNC;
            ABS0: state_d = ABS1;
            ZERO: state_d = dec.rmw ? RDWR : DATA;
            ABS1: begin
                if (dec.ind)                // Fetch pointer target
                    state_d = ABS0;
                else if (dec.jmp)
                    state_d = SYNC;
                else
                    state_d = dec.rmw ? RDWR : DATA;
            end
            RDWR: state_d = DATA;
            DATA: state_d = SYNC;
            PULL: state_d = DATA;
            PUSH: state_d = DATA;
            RTS0: state_d = RTS1;
            RTS1: state_d = RTS2;
            RTS2: state_d = SYNC;
            JSR0: state_d = JSR1;
            JSR1: state_d = JSR2;
            JSR2: state_d = ABS1;           // Target high byte
            BRK0: state_d = BRK1;
            BRK1: state_d = BRK2;
            BRK2: state_d = BRK3;
            BRK3: state_d = ABS0;           // Vector fetch
            RTI0: state_d = RTI1;
            RTI1: state_d = RTI2;
            RTI2: state_d = RTI3;
            RTI3: state_d = SYNC;
            COND: state_d = SYNC;
            default: state_d = INIT;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            state <= INIT;
        else
            state <= state_d;
    end

    assign sync = (state == SYNC);          // Opcode fetch cycle

endmodule
